// ==== dv/cp0_iui_assertions.sv ====
// CP0 EX1 interface assertions
// Exception versus write-back, mret change of flow, and single CSR
// write strobe while the instruction is stalled

`timescale 1ns/1ns

module cp0_iui_assertions (
  input logic                   regs_clk,
  input logic                   cpurst_b,
  input cp0_iui_pkg::rtu_ex1_t  rtu,
  input cp0_iui_pkg::wb_t       wb,
  input cp0_iui_pkg::regs_req_t regs_req,
  input logic                   ex1_stall
);

  // An excepting instruction never writes back
  expt_no_wb: assert property (@(posedge regs_clk) disable iff (!cpurst_b)
    !(rtu.expt_inst && wb.vld))
    else $error("exception and write-back valid together");

  // Change of flow only on a completing or stalled instruction
  chgflw_cmplt: assert property (@(posedge regs_clk) disable iff (!cpurst_b)
    rtu.chgflw_vld |-> (rtu.cmplt || ex1_stall))
    else $error("change of flow without completion or stall");

  // Second cycle of a stall must not strobe the write again
  wen_once: assert property (@(posedge regs_clk) disable iff (!cpurst_b)
    (regs_req.csr_wen && ex1_stall) |=> !(regs_req.csr_wen && ex1_stall))
    else $error("CSR write strobe repeated during stall");

endmodule

// ==== dv/cp0_iui_tb.sv ====
// CP0 EX1 interface testbench
// Directed and random instructions into the DUT, a reference model of
// the decode, exception, CSR and retire rules, and a compare process
// that checks every output field on the falling edge

`timescale 1ns/1ns
`include "cp0_iui_settings.svh"

module cp0_iui_tb;
  import cp0_iui_pkg::*;

  localparam int N_RAND    = 300;
  localparam int N_TESTS   = N_RAND + 40;

  typedef struct packed {
    regs_req_t    regs;
    special_req_t spc;
    cache_req_t   cache;
    logic         stall;
    rtu_ex1_t     rtu;
    wb_t          wb;
    logic         pend_next;
  } exp_t;

  logic         regs_clk;
  logic         cpurst_b;
  ex1_inst_t    inst;
  regs_rsp_t    regs_rsp;
  logic         dbgon;
  logic         wk_int;
  logic         cache_stall;
  logic         cache_expt_vld;
  logic         special_stall;
  logic         special_expt_vld;
  regs_req_t    regs_req;
  special_req_t special;
  cache_req_t   cache_req;
  logic         ex1_stall;
  rtu_ex1_t     rtu;
  wb_t          wb;

  integer       seed = 32'h9dcb_951e;
  int           err_cnt = 0;
  exp_t         exp_now = '0;
  logic         ref_pending;

  tb_clkgen i_clkgen (
    .regs_clk (regs_clk),
    .cpurst_b (cpurst_b)
  );

  cp0_iui_top i_cp0_iui_top (
    .regs_clk         (regs_clk),
    .cpurst_b         (cpurst_b),
    .inst             (inst),
    .regs_rsp         (regs_rsp),
    .dbgon            (dbgon),
    .wk_int           (wk_int),
    .cache_stall      (cache_stall),
    .cache_expt_vld   (cache_expt_vld),
    .special_stall    (special_stall),
    .special_expt_vld (special_expt_vld),
    .regs_req         (regs_req),
    .special          (special),
    .cache_req        (cache_req),
    .ex1_stall        (ex1_stall),
    .rtu              (rtu),
    .wb               (wb)
  );

  bind cp0_iui_top cp0_iui_assertions i_assertions (
    .regs_clk  (regs_clk),
    .cpurst_b  (cpurst_b),
    .rtu       (rtu),
    .wb        (wb),
    .regs_req  (regs_req),
    .ex1_stall (ex1_stall)
  );

  //--------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------
  function automatic exp_t ref_model(input ex1_inst_t in, input regs_rsp_t rsp,
                                     input logic dbg, input logic wk, input logic c_stall,
                                     input logic c_expt, input logic s_stall,
                                     input logic s_expt, input logic pend);
    exp_t       e;
    iui_op_e    op;
    logic [4:0] grp;
    logic [4:0] sf;
    logic       umode;
    logic       is_csr;
    logic       csr_bad;
    logic       priv_bad;
    logic       expt;
    logic       mret_ok;
    e     = '0;
    grp   = in.func[`IUI_GRP_LSB +: 5];
    sf    = in.func[4:0];
    umode = (rsp.pm == PM_USER);
    op    = OP_NONE;
    if (in.gateclk_sel && !in.expt_vld)
    begin
      if (grp[0])
        op = sf[3] ? OP_CSR_RO : OP_CSR;
      else if (grp[1])
      begin
        if (sf[0])
          op = OP_FENCE;
        else if (sf[1])
          op = OP_FENCEI;
        else if (sf[2])
          op = OP_SYNC;
        else if (sf[3])
          op = OP_SYNCI;
      end
      else if (grp[2])
      begin
        // ecall, mret and wfi vanish in debug mode
        if (sf[0])
          op = dbg ? OP_NONE : OP_ECALL;
        else if (sf[1])
          op = OP_EBREAK;
        else if (sf[2])
          op = dbg ? OP_NONE : OP_MRET;
        else if (sf[3])
          op = dbg ? OP_NONE : OP_WFI;
        else if (sf[4])
          op = OP_CACHE;
      end
      else if (grp[4] && sf[1] && dbg)
        op = OP_DRET;
    end
    is_csr   = (op == OP_CSR) || (op == OP_CSR_RO);
    csr_bad  = ((op == OP_CSR) && (in.imm[11:10] == 2'b11))
            || (umode && !dbg && is_csr && (in.imm[9:8] != 2'b00))
            || (is_csr && rsp.expt_vld) || ((op == OP_CACHE) && c_expt);
    priv_bad = umode && ((op == OP_MRET) || (op == OP_WFI));
    expt     = (in.expt_vld || csr_bad || priv_bad || s_expt) && in.gateclk_sel;
    mret_ok  = (op == OP_MRET) && !umode;

    if (is_csr && sf[0])
      e.regs.wdata = in.rs1;
    else if (is_csr && sf[1])
      e.regs.wdata = rsp.rdata | in.rs1;
    else if (is_csr && sf[2])
      e.regs.wdata = rsp.rdata & ~in.rs1;
    e.regs.csr_wen   = (op == OP_CSR) && !csr_bad && !pend;
    e.regs.inst_csr  = is_csr && !csr_bad;
    e.regs.inst_mret = mret_ok;
    e.regs.imm       = in.imm;
    e.spc.fence      = (op == OP_FENCE);
    e.spc.fencei     = (op == OP_FENCEI);
    e.spc.sync       = (op == OP_SYNC);
    e.spc.synci      = (op == OP_SYNCI);
    e.spc.ecall      = (op == OP_ECALL);
    e.spc.wfi        = (op == OP_WFI) && !umode;
    e.spc.int_vld    = wk;
    e.cache.cache    = (op == OP_CACHE);
    e.cache.imm      = e.cache.cache ? in.imm : '0;
    e.cache.rs1      = e.cache.cache ? in.rs1 : '0;
    e.stall          = ((op == OP_CACHE) && c_stall) || s_stall;

    e.rtu.cmplt      = in.sel && !e.stall;
    e.rtu.flush      = e.rtu.cmplt && !in.expt_vld && (op != OP_CSR_RO)
                    && (op != OP_FENCE) && (op != OP_SYNC);
    e.rtu.expt_inst  = expt;
    if (in.expt_vld && in.expt_type)
      e.rtu.expt_vec = EV_ACCFLT;
    else if ((in.expt_vld && !in.expt_type) || csr_bad || priv_bad)
      e.rtu.expt_vec = EV_ILLEGAL;
    else if ((op == OP_ECALL) && (rsp.pm == PM_MACHINE))
      e.rtu.expt_vec = EV_MECALL;
    else if ((op == OP_ECALL) && umode)
      e.rtu.expt_vec = EV_UECALL;
    else if (op == OP_EBREAK)
      e.rtu.expt_vec = EV_EBREAK;
    else
      e.rtu.expt_vec = EV_NONE;
    e.rtu.expt_tval  = in.gateclk_sel ? in.opcode : '0;
    e.rtu.chgflw_vld = mret_ok;
    e.rtu.chgflw_pc  = rsp.mepc[31:1];
    e.rtu.mret       = mret_ok;
    e.rtu.dret       = (op == OP_DRET);
    e.rtu.ebreak     = (op == OP_EBREAK);
    e.wb.vld         = e.rtu.cmplt && in.dst_vld && !expt;
    e.wb.preg        = in.dst_idx;
    e.wb.data        = expt ? in.opcode : rsp.rdata;
    // A stalled write request blocks the strobe on the next cycle
    e.pend_next      = (op == OP_CSR) && !csr_bad && e.stall;
    return e;
  endfunction

  //--------------------------------------------------------------------
  // Checking
  //--------------------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("error %s: got %h, expected %h", name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "output mismatch at %0t", $time);
    end
  endtask

  task automatic compare_outputs(input exp_t e);
    check_value("regs_req.csr_wen", regs_req.csr_wen, e.regs.csr_wen);
    check_value("regs_req.inst_csr", regs_req.inst_csr, e.regs.inst_csr);
    check_value("regs_req.inst_mret", regs_req.inst_mret, e.regs.inst_mret);
    check_value("regs_req.imm", regs_req.imm, e.regs.imm);
    check_value("regs_req.wdata", regs_req.wdata, e.regs.wdata);
    check_value("special", special, e.spc);
    check_value("cache_req", cache_req, e.cache);
    check_value("ex1_stall", ex1_stall, e.stall);
    check_value("rtu.cmplt", rtu.cmplt, e.rtu.cmplt);
    check_value("rtu.flush", rtu.flush, e.rtu.flush);
    check_value("rtu.expt_inst", rtu.expt_inst, e.rtu.expt_inst);
    check_value("rtu.expt_vec", rtu.expt_vec, e.rtu.expt_vec);
    check_value("rtu.expt_tval", rtu.expt_tval, e.rtu.expt_tval);
    check_value("rtu.chgflw_vld", rtu.chgflw_vld, e.rtu.chgflw_vld);
    check_value("rtu.chgflw_pc", rtu.chgflw_pc, e.rtu.chgflw_pc);
    check_value("rtu.mret", rtu.mret, e.rtu.mret);
    check_value("rtu.dret", rtu.dret, e.rtu.dret);
    check_value("rtu.ebreak", rtu.ebreak, e.rtu.ebreak);
    check_value("wb.vld", wb.vld, e.wb.vld);
    check_value("wb.preg", wb.preg, e.wb.preg);
    check_value("wb.data", wb.data, e.wb.data);
  endtask

  // Outputs settle between edges, so compare on the falling edge
  always @(negedge regs_clk)
  begin
    exp_now = ref_model(inst, regs_rsp, dbgon, wk_int, cache_stall, cache_expt_vld,
                        special_stall, special_expt_vld, ref_pending);
    if (cpurst_b)
      compare_outputs(exp_now);
  end

  always @(posedge regs_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ref_pending <= 1'b0;
    else
      ref_pending <= exp_now.pend_next;
  end

  //--------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------
  function automatic logic one_in(input int n);
    return (($unsigned($random(seed)) % n) == 0);
  endfunction

  task automatic clear_inputs();
    inst             <= '0;
    regs_rsp         <= '0;
    dbgon            <= 1'b0;
    wk_int           <= 1'b0;
    cache_stall      <= 1'b0;
    cache_expt_vld   <= 1'b0;
    special_stall    <= 1'b0;
    special_expt_vld <= 1'b0;
  endtask

  // One valid instruction; grp below zero sets no group bit
  task automatic send(input int grp, input logic [4:0] sf, input logic [11:0] imm,
                      input priv_mode_e pm);
    logic [`IUI_FUNC_W-1:0] func;
    func = '0;
    if (grp >= 0)
      func[`IUI_GRP_LSB + grp] = 1'b1;
    func[4:0] = sf;
    @(posedge regs_clk);
    clear_inputs();
    inst.sel         <= 1'b1;
    inst.gateclk_sel <= 1'b1;
    inst.func        <= func;
    inst.imm         <= imm;
    inst.rs1         <= $random(seed);
    inst.opcode      <= $random(seed);
    inst.dst_vld     <= 1'b1;
    inst.dst_idx     <= 6'($random(seed));
    regs_rsp.rdata   <= $random(seed);
    regs_rsp.mepc    <= $random(seed);
    regs_rsp.pm      <= pm;
  endtask

  task automatic send_random();
    int   gsel;
    int   grp;
    logic gate;
    gsel = int'($unsigned($random(seed)) % 6);
    case (gsel)
      0, 5:    grp = 0;
      1:       grp = 1;
      2:       grp = 2;
      3:       grp = 4;
      default: grp = -1;
    endcase
    send(grp, 5'($random(seed)), 12'($random(seed)),
         ($random(seed) & 1) ? PM_USER : PM_MACHINE);
    gate = !one_in(8);
    inst.sel             <= gate;
    inst.gateclk_sel     <= gate;
    inst.expt_vld        <= one_in(8);
    inst.expt_type       <= one_in(2);
    inst.dst_vld         <= one_in(2);
    regs_rsp.expt_vld    <= one_in(8);
    dbgon                <= one_in(4);
    wk_int               <= one_in(2);
    cache_stall          <= one_in(4);
    cache_expt_vld       <= one_in(4);
    special_stall        <= one_in(8);
    special_expt_vld     <= one_in(16);
  endtask

  initial
  begin
    clear_inputs();
    @(posedge cpurst_b);
    // CSR read-modify-write forms and a read-only access
    send(0, 5'b00001, 12'h300, PM_MACHINE);
    send(0, 5'b00010, 12'h305, PM_MACHINE);
    send(0, 5'b00100, 12'h341, PM_MACHINE);
    send(0, 5'b01001, 12'hc01, PM_MACHINE);
    // Illegal CSR accesses
    send(0, 5'b00001, 12'h100, PM_USER);
    send(0, 5'b00010, 12'hc00, PM_MACHINE);
    send(0, 5'b00001, 12'h300, PM_MACHINE);
    regs_rsp.expt_vld <= 1'b1;
    // ecall, ebreak and decoder exceptions
    send(2, 5'b00001, 12'h000, PM_MACHINE);
    send(2, 5'b00001, 12'h000, PM_USER);
    send(2, 5'b00010, 12'h000, PM_MACHINE);
    send(2, 5'b00001, 12'h000, PM_MACHINE);
    inst.expt_vld  <= 1'b1;
    inst.expt_type <= 1'b1;
    send(2, 5'b00001, 12'h000, PM_USER);
    inst.expt_vld  <= 1'b1;
    // fence, sync and wfi strobes
    send(1, 5'b00001, 12'h000, PM_MACHINE);
    send(1, 5'b00010, 12'h000, PM_MACHINE);
    send(1, 5'b00100, 12'h000, PM_MACHINE);
    send(1, 5'b01000, 12'h000, PM_MACHINE);
    send(2, 5'b01000, 12'h000, PM_MACHINE);
    send(2, 5'b01000, 12'h000, PM_USER);
    // mret in machine, user and debug mode
    send(2, 5'b00100, 12'h000, PM_MACHINE);
    send(2, 5'b00100, 12'h000, PM_USER);
    send(2, 5'b00100, 12'h000, PM_MACHINE);
    dbgon <= 1'b1;
    // Cache op under stall, dret in debug mode
    send(2, 5'b10000, 12'h0a5, PM_MACHINE);
    cache_stall <= 1'b1;
    send(4, 5'b00010, 12'h000, PM_MACHINE);
    dbgon <= 1'b1;
    // CSR write held for three cycles
    send(0, 5'b00010, 12'h300, PM_MACHINE);
    special_stall <= 1'b1;
    repeat (3) @(posedge regs_clk);
    special_stall <= 1'b0;
    @(posedge regs_clk);
    clear_inputs();
    repeat (N_RAND) send_random();
    @(posedge regs_clk);
    clear_inputs();
    repeat (2) @(posedge regs_clk);
    if (err_cnt == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (N_TESTS * 20) @(posedge regs_clk);
    $display("ERRORS FOUND");
    $fatal(1, "timeout, the test sequence did not finish in time");
  end

endmodule

// ==== dv/tb_clkgen.sv ====
// Testbench clock and reset source
// 10 ns regs_clk, cpurst_b held low for the first 4 rising edges

`timescale 1ns/1ns

module tb_clkgen (
  output logic regs_clk,
  output logic cpurst_b
);

  initial
  begin
    regs_clk = 1'b0;
    forever
      #5 regs_clk = ~regs_clk;
  end

  // Release away from the rising edge
  initial
  begin
    cpurst_b = 1'b0;
    repeat (4) @(posedge regs_clk);
    #2;
    cpurst_b = 1'b1;
  end

endmodule

// ==== include/cp0_iui_settings.svh ====
// CP0 EX1 interface settings
// Widths and field positions shared by the CP0 instruction unit

`ifndef CP0_IUI_SETTINGS_SVH
`define CP0_IUI_SETTINGS_SVH

// Data path and PC width
`define IUI_XLEN        32

// CSR index carried in the immediate field
`define IUI_CSR_ADDR_W  12

// Destination physical register index
`define IUI_PREG_W      6

// Decoder func field and position of its one-hot group bits
`define IUI_FUNC_W      20
`define IUI_GRP_LSB     5

// Exception vector width toward retire
`define IUI_EXPT_VEC_W  4

`endif

// ==== logic/cp0_iui_csr_wdata.sv ====
// CSR write data and write strobe
// Builds the CSRRW/CSRRS/CSRRC write data and holds the pending flag
// that limits the write strobe to the first cycle of a stalled write

`timescale 1ns/1ns
`include "cp0_iui_settings.svh"

module cp0_iui_csr_wdata (
  input  logic                   regs_clk,
  input  logic                   cpurst_b,
  input  cp0_iui_pkg::iui_op_e   op,
  input  cp0_iui_pkg::csr_func_e csr_func,
  input  logic [`IUI_XLEN-1:0]   rs1,
  input  logic [`IUI_XLEN-1:0]   rdata,
  input  logic                   csr_expt_vld,
  input  logic                   stall,
  output logic                   csr_wen,
  output logic [`IUI_XLEN-1:0]   wdata
);
  import cp0_iui_pkg::*;

  logic wen_req;
  logic wen_pending;

  // Read-modify-write data
  always_comb
  begin
    case (csr_func)
      CSR_RW:  wdata = rs1;
      CSR_RS:  wdata = rdata | rs1;
      CSR_RC:  wdata = rdata & ~rs1;
      default: wdata = '0;
    endcase
  end

  assign wen_req = (op == OP_CSR) && !csr_expt_vld;

  // Stays set for as long as the write is held by a stall, and one
  // cycle past it, so the write lands only once
  always_ff @(posedge regs_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      wen_pending <= 1'b0;
    else
      wen_pending <= wen_req && stall;
  end

  assign csr_wen = wen_req && !wen_pending;

endmodule

// ==== logic/cp0_iui_decode.sv ====
// CP0 instruction decode
// Turns the one-hot group bits and sub-func bits of the decoder func
// field into a single opcode, with debug-mode gating, and gives the
// CSR read-modify-write form for CSR accesses

`timescale 1ns/1ns
`include "cp0_iui_settings.svh"

module cp0_iui_decode (
  input  cp0_iui_pkg::ex1_inst_t inst,
  input  logic                   dbgon,
  output cp0_iui_pkg::iui_op_e   op,
  output cp0_iui_pkg::csr_func_e csr_func
);
  import cp0_iui_pkg::*;

  logic       inst_vld;
  logic       grp_csr;
  logic       grp_sync;
  logic       grp_sys;
  logic       grp_dbg;
  logic [4:0] sub_func;

  // Decoder exceptions never decode into an operation
  assign inst_vld = inst.gateclk_sel && !inst.expt_vld;

  assign grp_csr  = inst.func[`IUI_GRP_LSB];
  assign grp_sync = inst.func[`IUI_GRP_LSB + 1];
  assign grp_sys  = inst.func[`IUI_GRP_LSB + 2];
  assign grp_dbg  = inst.func[`IUI_GRP_LSB + 4];
  assign sub_func = inst.func[4:0];

  //--------------------------------------------------------------------
  // Opcode
  //--------------------------------------------------------------------
  always_comb
  begin
    op = OP_NONE;
    if (!inst_vld)
      op = OP_NONE;
    else if (grp_csr && sub_func[3])
      op = OP_CSR_RO;
    else if (grp_csr)
      op = OP_CSR;
    else if (grp_sync && sub_func[0])
      op = OP_FENCE;
    else if (grp_sync && sub_func[1])
      op = OP_FENCEI;
    else if (grp_sync && sub_func[2])
      op = OP_SYNC;
    else if (grp_sync && sub_func[3])
      op = OP_SYNCI;
    else if (grp_sys && sub_func[0])
    begin
      // ecall is ignored while halted in debug mode
      if (!dbgon)
        op = OP_ECALL;
    end
    else if (grp_sys && sub_func[1])
      op = OP_EBREAK;
    else if (grp_sys && sub_func[2])
    begin
      if (!dbgon)
        op = OP_MRET;
    end
    else if (grp_sys && sub_func[3])
    begin
      if (!dbgon)
        op = OP_WFI;
    end
    else if (grp_sys && sub_func[4])
      op = OP_CACHE;
    else if (grp_dbg && sub_func[1] && dbgon)
      op = OP_DRET;
  end

  // CSR form from func bits 0 to 2
  always_comb
  begin
    csr_func = CSR_NONE;
    if (op == OP_CSR || op == OP_CSR_RO)
    begin
      if (sub_func[0])
        csr_func = CSR_RW;
      else if (sub_func[1])
        csr_func = CSR_RS;
      else if (sub_func[2])
        csr_func = CSR_RC;
    end
  end

endmodule

// ==== logic/cp0_iui_expt.sv ====
// CP0 exception check
// Privilege and read-only CSR checks, illegal mret and wfi in user
// mode, and the fixed-priority pick of one exception vector

`timescale 1ns/1ns

module cp0_iui_expt (
  input  cp0_iui_pkg::ex1_inst_t  inst,
  input  cp0_iui_pkg::iui_op_e    op,
  input  cp0_iui_pkg::priv_mode_e pm,
  input  logic                    dbgon,
  input  logic                    regs_expt_vld,
  input  logic                    cache_expt_vld,
  input  logic                    special_expt_vld,
  output logic                    csr_expt_vld,
  output logic                    expt_vld,
  output cp0_iui_pkg::expt_vec_e  expt_vec,
  output logic                    mret_vld,
  output logic                    wfi_vld
);
  import cp0_iui_pkg::*;

  logic umode;
  logic inst_csr;
  logic csr_write_inv;
  logic csr_umode_inv;
  logic mret_umode_inv;
  logic wfi_umode_inv;
  logic accflt_vld;
  logic illegal_vld;
  logic mecall_vld;
  logic uecall_vld;
  logic ebreak_vld;

  assign umode    = (pm == PM_USER);
  assign inst_csr = (op == OP_CSR) || (op == OP_CSR_RO);

  //--------------------------------------------------------------------
  // Access checks
  //--------------------------------------------------------------------
  // imm[11:10] == 3 marks a read-only CSR
  assign csr_write_inv  = (op == OP_CSR) && (inst.imm[11:10] == 2'b11);
  // imm[9:8] is the lowest privilege allowed to touch the CSR
  assign csr_umode_inv  = umode && !dbgon && inst_csr && (inst.imm[9:8] != 2'b00);
  assign mret_umode_inv = umode && (op == OP_MRET);
  assign wfi_umode_inv  = umode && (op == OP_WFI);

  assign csr_expt_vld = csr_write_inv || csr_umode_inv
                     || (inst_csr && regs_expt_vld)
                     || ((op == OP_CACHE) && cache_expt_vld);

  assign expt_vld = (inst.expt_vld || csr_expt_vld || mret_umode_inv
                  || wfi_umode_inv || special_expt_vld) && inst.gateclk_sel;

  // Vector sources
  assign accflt_vld  = inst.expt_vld && inst.expt_type;
  assign illegal_vld = (inst.expt_vld && !inst.expt_type) || csr_expt_vld
                    || mret_umode_inv || wfi_umode_inv;
  assign mecall_vld  = (op == OP_ECALL) && (pm == PM_MACHINE);
  assign uecall_vld  = (op == OP_ECALL) && umode;
  assign ebreak_vld  = (op == OP_EBREAK);

  always_comb
  begin
    if (accflt_vld)
      expt_vec = EV_ACCFLT;
    else if (illegal_vld)
      expt_vec = EV_ILLEGAL;
    else if (mecall_vld)
      expt_vec = EV_MECALL;
    else if (uecall_vld)
      expt_vec = EV_UECALL;
    else if (ebreak_vld)
      expt_vec = EV_EBREAK;
    else
      expt_vec = EV_NONE;
  end

  // mret and wfi that are allowed to proceed
  assign mret_vld = (op == OP_MRET) && !mret_umode_inv;
  assign wfi_vld  = (op == OP_WFI) && !wfi_umode_inv;

endmodule

// ==== logic/cp0_iui_pkg.sv ====
// CP0 EX1 interface types
// Opcode, CSR form, privilege and vector enums plus the bus structs

`include "cp0_iui_settings.svh"

package cp0_iui_pkg;

  typedef enum logic [3:0] {
    OP_NONE, OP_CSR, OP_CSR_RO, OP_FENCE, OP_FENCEI, OP_SYNC, OP_SYNCI,
    OP_ECALL, OP_EBREAK, OP_MRET, OP_WFI, OP_CACHE, OP_DRET
  } iui_op_e;

  typedef enum logic [1:0] {CSR_NONE, CSR_RW, CSR_RS, CSR_RC} csr_func_e;

  typedef enum logic [1:0] {PM_USER = 2'd0, PM_MACHINE = 2'd3} priv_mode_e;

  typedef enum logic [`IUI_EXPT_VEC_W-1:0] {
    EV_NONE = 4'd0, EV_ACCFLT = 4'd1, EV_ILLEGAL = 4'd2, EV_EBREAK = 4'd3,
    EV_UECALL = 4'd8, EV_MECALL = 4'd11
  } expt_vec_e;

  // Instruction issued by the decoder into EX1
  typedef struct packed {
    logic                        sel;
    logic                        gateclk_sel;
    logic                        expt_vld;
    logic                        expt_type;
    logic [`IUI_FUNC_W-1:0]      func;
    logic [`IUI_XLEN-1:0]        rs1;
    logic [`IUI_CSR_ADDR_W-1:0]  imm;
    logic [`IUI_XLEN-1:0]        opcode;
    logic                        dst_vld;
    logic [`IUI_PREG_W-1:0]      dst_idx;
  } ex1_inst_t;

  // CSR file response
  typedef struct packed {
    logic [`IUI_XLEN-1:0] rdata;
    logic [`IUI_XLEN-1:0] mepc;
    priv_mode_e           pm;
    logic                 expt_vld;
  } regs_rsp_t;

  // CSR file request
  typedef struct packed {
    logic                       csr_wen;
    logic                       inst_csr;
    logic                       inst_mret;
    logic [`IUI_CSR_ADDR_W-1:0] imm;
    logic [`IUI_XLEN-1:0]       wdata;
  } regs_req_t;

  // Strobes toward the fence, sync, ecall and wfi handler
  typedef struct packed {
    logic fence;
    logic fencei;
    logic sync;
    logic synci;
    logic ecall;
    logic wfi;
    logic int_vld;
  } special_req_t;

  // Cache operation request, all fields gated by the cache opcode
  typedef struct packed {
    logic                       cache;
    logic [`IUI_CSR_ADDR_W-1:0] imm;
    logic [`IUI_XLEN-1:0]       rs1;
  } cache_req_t;

  typedef struct packed {
    logic                 cmplt;
    logic                 flush;
    logic                 expt_inst;
    expt_vec_e            expt_vec;
    logic [`IUI_XLEN-1:0] expt_tval;
    logic                 chgflw_vld;
    logic [`IUI_XLEN-2:0] chgflw_pc;
    logic                 mret;
    logic                 dret;
    logic                 ebreak;
  } rtu_ex1_t;

  typedef struct packed {
    logic                   vld;
    logic [`IUI_PREG_W-1:0] preg;
    logic [`IUI_XLEN-1:0]   data;
  } wb_t;

endpackage

// ==== logic/cp0_iui_retire.sv ====
// CP0 retire interface
// Completion, stall, flush, mret change of flow and register
// write-back for the retire unit

`timescale 1ns/1ns
`include "cp0_iui_settings.svh"

module cp0_iui_retire (
  input  cp0_iui_pkg::ex1_inst_t inst,
  input  cp0_iui_pkg::iui_op_e   op,
  input  logic                   expt_vld,
  input  cp0_iui_pkg::expt_vec_e expt_vec,
  input  logic                   mret_vld,
  input  logic [`IUI_XLEN-1:0]   mepc,
  input  logic [`IUI_XLEN-1:0]   rdata,
  input  logic                   cache_stall,
  input  logic                   special_stall,
  output logic                   stall,
  output cp0_iui_pkg::rtu_ex1_t  rtu,
  output cp0_iui_pkg::wb_t       wb
);
  import cp0_iui_pkg::*;

  logic cmplt;
  logic no_flush_op;

  // Cache stall only counts for a cache op
  assign stall = ((op == OP_CACHE) && cache_stall) || special_stall;
  assign cmplt = inst.sel && !stall;

  // Read-only CSR, fence and sync retire without a pipeline flush
  assign no_flush_op = (op == OP_CSR_RO) || (op == OP_FENCE) || (op == OP_SYNC);

  //--------------------------------------------------------------------
  // Retire unit
  //--------------------------------------------------------------------
  assign rtu.cmplt      = cmplt;
  assign rtu.flush      = cmplt && !inst.expt_vld && !no_flush_op;
  assign rtu.expt_inst  = expt_vld;
  assign rtu.expt_vec   = expt_vec;
  assign rtu.expt_tval  = {`IUI_XLEN{inst.gateclk_sel}} & inst.opcode;
  assign rtu.chgflw_vld = mret_vld;
  assign rtu.chgflw_pc  = mepc[`IUI_XLEN-1:1];
  assign rtu.mret       = mret_vld;
  assign rtu.dret       = (op == OP_DRET);
  assign rtu.ebreak     = (op == OP_EBREAK);

  // Write-back of the CSR read value, or the opcode on an exception
  assign wb.vld  = cmplt && inst.dst_vld && !expt_vld;
  assign wb.preg = inst.dst_idx;
  assign wb.data = expt_vld ? inst.opcode : rdata;

endmodule

// ==== logic/cp0_iui_top.sv ====
// CP0 EX1 instruction unit
// Decodes CP0 instructions from the decoder, drives CSR file requests,
// special-instruction strobes and cache requests, and reports
// completion, exceptions and write-back to the retire unit

`timescale 1ns/1ns
`include "cp0_iui_settings.svh"

module cp0_iui_top (
  input  logic                      regs_clk,
  input  logic                      cpurst_b,
  input  cp0_iui_pkg::ex1_inst_t    inst,
  input  cp0_iui_pkg::regs_rsp_t    regs_rsp,
  input  logic                      dbgon,
  input  logic                      wk_int,
  input  logic                      cache_stall,
  input  logic                      cache_expt_vld,
  input  logic                      special_stall,
  input  logic                      special_expt_vld,
  output cp0_iui_pkg::regs_req_t    regs_req,
  output cp0_iui_pkg::special_req_t special,
  output cp0_iui_pkg::cache_req_t   cache_req,
  output logic                      ex1_stall,
  output cp0_iui_pkg::rtu_ex1_t     rtu,
  output cp0_iui_pkg::wb_t          wb
);
  import cp0_iui_pkg::*;

  iui_op_e              op;
  csr_func_e            csr_func;
  logic                 csr_expt_vld;
  logic                 expt_vld;
  expt_vec_e            expt_vec;
  logic                 mret_vld;
  logic                 wfi_vld;
  logic                 stall;
  logic                 csr_wen;
  logic [`IUI_XLEN-1:0] csr_wdata;

  cp0_iui_decode i_decode (
    .inst     (inst),
    .dbgon    (dbgon),
    .op       (op),
    .csr_func (csr_func)
  );

  cp0_iui_csr_wdata i_csr_wdata (
    .regs_clk     (regs_clk),
    .cpurst_b     (cpurst_b),
    .op           (op),
    .csr_func     (csr_func),
    .rs1          (inst.rs1),
    .rdata        (regs_rsp.rdata),
    .csr_expt_vld (csr_expt_vld),
    .stall        (stall),
    .csr_wen      (csr_wen),
    .wdata        (csr_wdata)
  );

  cp0_iui_expt i_expt (
    .inst             (inst),
    .op               (op),
    .pm               (regs_rsp.pm),
    .dbgon            (dbgon),
    .regs_expt_vld    (regs_rsp.expt_vld),
    .cache_expt_vld   (cache_expt_vld),
    .special_expt_vld (special_expt_vld),
    .csr_expt_vld     (csr_expt_vld),
    .expt_vld         (expt_vld),
    .expt_vec         (expt_vec),
    .mret_vld         (mret_vld),
    .wfi_vld          (wfi_vld)
  );

  cp0_iui_retire i_retire (
    .inst          (inst),
    .op            (op),
    .expt_vld      (expt_vld),
    .expt_vec      (expt_vec),
    .mret_vld      (mret_vld),
    .mepc          (regs_rsp.mepc),
    .rdata         (regs_rsp.rdata),
    .cache_stall   (cache_stall),
    .special_stall (special_stall),
    .stall         (stall),
    .rtu           (rtu),
    .wb            (wb)
  );

  //--------------------------------------------------------------------
  // Output buses
  //--------------------------------------------------------------------
  assign regs_req.csr_wen   = csr_wen;
  assign regs_req.inst_csr  = ((op == OP_CSR) || (op == OP_CSR_RO)) && !csr_expt_vld;
  assign regs_req.inst_mret = mret_vld;
  assign regs_req.imm       = inst.imm;
  assign regs_req.wdata     = csr_wdata;

  assign special.fence   = (op == OP_FENCE);
  assign special.fencei  = (op == OP_FENCEI);
  assign special.sync    = (op == OP_SYNC);
  assign special.synci   = (op == OP_SYNCI);
  assign special.ecall   = (op == OP_ECALL);
  assign special.wfi     = wfi_vld;
  assign special.int_vld = wk_int;

  assign cache_req.cache = (op == OP_CACHE);
  assign cache_req.imm   = {`IUI_CSR_ADDR_W{cache_req.cache}} & inst.imm;
  assign cache_req.rs1   = {`IUI_XLEN{cache_req.cache}} & inst.rs1;

  assign ex1_stall = stall;

endmodule

// ==== project.f ====
+incdir+include
logic/cp0_iui_pkg.sv
logic/cp0_iui_decode.sv
logic/cp0_iui_csr_wdata.sv
logic/cp0_iui_expt.sv
logic/cp0_iui_retire.sv
logic/cp0_iui_top.sv
dv/tb_clkgen.sv
dv/cp0_iui_assertions.sv
dv/cp0_iui_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the CP0 EX1 interface simulation with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module cp0_iui_tb -o cp0_iui_sim &&
./obj_dir/cp0_iui_sim | tee /dev/stderr | grep -q -x "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
